// File: sysCtrlPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the system control block.
//   - bus address, data and lane widths
//   - register address map as an enum
//   - field widths for selects and the reboot address
//   - version, image type and reset pulse length constants
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sysCtrlPkg;

    // host bus shape
    localparam int addrWidth = 13;                  // word address bits.
    localparam int dataWidth = 32;                  // data bus bits.
    localparam int laneCount = 4;                   // one write enable per byte.

    // field widths
    localparam int dacSelWidth     = 3;             // per dac input select.
    localparam int muxSelWidth     = 4;             // per routing select.
    localparam int rebootAddrWidth = 24;            // flash image start address.

    // read-only identification words
    localparam logic [15:0] versionNumber = 16'h0104;   // firmware release.
    localparam logic [15:0] imageType     = 16'h00b5;   // bitsync plus bert image.

    // subsystemReset stays high this many dataClk cycles
    localparam int resetPulseLength = 6;

    // register map, regNone covers every unmapped address
    typedef enum logic [addrWidth-1:0] {
        regVersion       = 13'h0000,
        regSubsystemCtrl = 13'h0001,
        regType          = 13'h0002,
        regDacInputSel   = 13'h0003,
        regOutputSel     = 13'h0004,
        regBertMuxSel    = 13'h0005,
        regFramerMuxSel  = 13'h0006,
        regReboot        = 13'h0007,
        regReset         = 13'h0008,
        regNone          = 13'h1fff
    } regAddrT;

endpackage

// File: busDecode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus decode stage.
//   - combinational address decode for the read path
//   - one-cycle registered write strobe, selector, lanes and data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module busDecode import sysCtrlPkg::*; (
    input  logic                 busClk,
    input  logic                 rs,
    input  logic                 cs,
    input  logic [addrWidth-1:0] addr,
    input  logic [dataWidth-1:0] dataIn,
    input  logic [laneCount-1:0] wr,
    output regAddrT              rdSel,
    output regAddrT              wrSel,
    output logic [laneCount-1:0] wrLanes,
    output logic [dataWidth-1:0] wrData,
    output logic                 wrStrobe
);

    logic busWrite;

    assign busWrite = cs && (|wr);                  // any lane counts as a write.

    // map the raw address onto the register set
    always_comb begin
        case (addr)
            regVersion, regSubsystemCtrl, regType, regDacInputSel,
            regOutputSel, regBertMuxSel, regFramerMuxSel, regReboot,
            regReset: rdSel = regAddrT'(addr);
            default:  rdSel = regNone;              // unmapped.
        endcase
    end

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            wrStrobe <= 1'b0;
            wrSel    <= regNone;
            wrLanes  <= '0;
            wrData   <= '0;
        end else begin
            wrStrobe <= busWrite;                   // high for one cycle per write.
            if (busWrite) begin
                wrSel   <= rdSel;
                wrLanes <= wr;
                wrData  <= dataIn;
            end
        end
    end

endmodule

// File: sysRegFile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register file in the bus clock domain.
//   - subsystem enables, dac input selects, output routing selects
//   - bert and framer mux selects, reboot address
//   - combinational readback with version and image words
//   - soft-reset and reboot command strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sysRegFile import sysCtrlPkg::*; (
    input  logic                       busClk,
    input  logic                       rs,
    input  logic                       cs,
    input  regAddrT                    rdSel,
    input  regAddrT                    wrSel,
    input  logic [laneCount-1:0]       wrLanes,
    input  logic [dataWidth-1:0]       wrData,
    input  logic                       wrStrobe,
    output logic [dataWidth-1:0]       dataOut,
    output logic                       bitsyncEnable,
    output logic                       bertEnable,
    output logic                       framesyncEnable,
    output logic                       pnGeneratorEnable,
    output logic [dacSelWidth-1:0]     dac0InputSelect,
    output logic [dacSelWidth-1:0]     dac1InputSelect,
    output logic [dacSelWidth-1:0]     dac2InputSelect,
    output logic [muxSelWidth-1:0]     bsCoaxMuxSelect,
    output logic [muxSelWidth-1:0]     encCoaxMuxSelect,
    output logic [muxSelWidth-1:0]     fsMuxSelect,
    output logic [muxSelWidth-1:0]     bsRS422MuxSelect,
    output logic [muxSelWidth-1:0]     fsRS422MuxSelect,
    output logic [muxSelWidth-1:0]     bertMuxSelect,
    output logic [muxSelWidth-1:0]     framerMuxSelect,
    output logic [rebootAddrWidth-1:0] rebootAddress,
    output logic                       resetCmd,
    output logic                       rebootCmd
);

    logic lane0;
    logic lane1;
    logic lane2;

    // lane 3 carries no fields in this map
    assign lane0 = wrStrobe && wrLanes[0];
    assign lane1 = wrStrobe && wrLanes[1];
    assign lane2 = wrStrobe && wrLanes[2];

    assign resetCmd  = lane0 && (wrSel == regReset);    // soft reset request.
    assign rebootCmd = lane2 && (wrSel == regReboot);   // top address byte fires reboot.

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            bitsyncEnable     <= 1'b0;
            bertEnable        <= 1'b0;
            framesyncEnable   <= 1'b0;
            pnGeneratorEnable <= 1'b0;
            dac0InputSelect   <= '0;
            dac1InputSelect   <= '0;
            dac2InputSelect   <= '0;
            bsCoaxMuxSelect   <= '0;
            bsRS422MuxSelect  <= '0;
            encCoaxMuxSelect  <= '0;
            fsMuxSelect       <= '0;
            fsRS422MuxSelect  <= '0;
            bertMuxSelect     <= '0;
            framerMuxSelect   <= '0;
            rebootAddress     <= '0;
        end else begin
            if (lane0) begin
                case (wrSel)
                    regSubsystemCtrl: begin
                        bitsyncEnable     <= wrData[0];
                        bertEnable        <= wrData[1];
                        framesyncEnable   <= wrData[2];
                        pnGeneratorEnable <= wrData[3];
                    end
                    regDacInputSel: dac0InputSelect <= wrData[dacSelWidth-1:0];
                    regOutputSel: begin
                        bsCoaxMuxSelect  <= wrData[3:0];     // nibble 0.
                        bsRS422MuxSelect <= wrData[7:4];     // nibble 1.
                    end
                    regBertMuxSel: bertMuxSelect <= wrData[3:0];
                    regReboot:     rebootAddress[7:0] <= wrData[7:0];
                    default: ;
                endcase
            end
            if (lane1) begin
                case (wrSel)
                    regDacInputSel: dac1InputSelect <= wrData[8+dacSelWidth-1:8];
                    regOutputSel:   encCoaxMuxSelect <= wrData[11:8];
                    regReboot:      rebootAddress[15:8] <= wrData[15:8];
                    default: ;
                endcase
            end
            if (lane2) begin
                case (wrSel)
                    regDacInputSel: dac2InputSelect <= wrData[16+dacSelWidth-1:16];
                    regOutputSel: begin
                        fsMuxSelect      <= wrData[19:16];  // nibble 4.
                        fsRS422MuxSelect <= wrData[23:20];  // nibble 5.
                    end
                    regFramerMuxSel: framerMuxSelect <= wrData[19:16];
                    regReboot:       rebootAddress[23:16] <= wrData[23:16];
                    default: ;
                endcase
            end
        end
    end

    // readback, zero when not selected.
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (rdSel)
                regVersion:       dataOut = {versionNumber, 16'h0000};
                regSubsystemCtrl: dataOut = {28'h0, pnGeneratorEnable, framesyncEnable,
                                             bertEnable, bitsyncEnable};
                regType:          dataOut = {16'h0000, imageType};
                regDacInputSel:   dataOut = {8'h00,
                                             {(8-dacSelWidth){1'b0}}, dac2InputSelect,
                                             {(8-dacSelWidth){1'b0}}, dac1InputSelect,
                                             {(8-dacSelWidth){1'b0}}, dac0InputSelect};
                regOutputSel:     dataOut = {8'h00, fsRS422MuxSelect, fsMuxSelect,
                                             {muxSelWidth{1'b0}}, encCoaxMuxSelect,
                                             bsRS422MuxSelect, bsCoaxMuxSelect};
                regBertMuxSel, regFramerMuxSel:
                    dataOut = {{(16-muxSelWidth){1'b0}}, framerMuxSelect,
                               {(16-muxSelWidth){1'b0}}, bertMuxSelect};
                default:          dataOut = '0;     // commands and unmapped.
            endcase
        end
    end

endmodule

// File: pulseSync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle strobe crossing from busClk into dataClk.
//   - source toggle flop, two-flop synchronizer, edge detector
//   - strobes must be at least four dataClk cycles apart
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pulseSync (
    input  logic busClk,
    input  logic dataClk,
    input  logic rs,
    input  logic pulseIn,
    output logic pulseOut
);

    logic       srcToggle;
    logic [1:0] syncFf;
    logic       syncLast;

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            srcToggle <= 1'b0;
        end else if (pulseIn) begin
            srcToggle <= ~srcToggle;                // one flip per strobe.
        end
    end

    always_ff @(posedge dataClk or posedge rs) begin
        if (rs) begin
            syncFf   <= '0;
            syncLast <= 1'b0;
        end else begin
            syncFf   <= {syncFf[0], srcToggle};     // metastability guard.
            syncLast <= syncFf[1];
        end
    end

    // each toggle edge gives one dataClk cycle
    assign pulseOut = syncFf[1] ^ syncLast;

endmodule

// File: resetPulseGen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subsystem reset stretcher in the dataClk domain.
//   - down-counter loaded on each synchronized soft-reset pulse
//   - registered output held for resetPulseLength cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module resetPulseGen import sysCtrlPkg::*; (
    input  logic dataClk,
    input  logic rs,
    input  logic resetSync,
    output logic subsystemReset
);

    logic [$clog2(resetPulseLength+1)-1:0] pulseCount;

    // the first high cycle is the load cycle, so the
    // counter covers the remaining length minus one.
    always_ff @(posedge dataClk or posedge rs) begin
        if (rs) begin
            pulseCount     <= '0;
            subsystemReset <= 1'b0;
        end else if (resetSync) begin
            pulseCount     <= $bits(pulseCount)'(resetPulseLength - 1);  // restart.
            subsystemReset <= 1'b1;
        end else if (pulseCount != '0) begin
            pulseCount     <= pulseCount - 1'b1;
            subsystemReset <= 1'b1;
        end else begin
            subsystemReset <= 1'b0;
        end
    end

endmodule

// File: sysCtrlTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System control block top level.
//   - bus decode, register file
//   - soft-reset and reboot crossings into dataClk
//   - subsystem reset pulse generator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sysCtrlTop import sysCtrlPkg::*; (
    input  logic                       busClk,
    input  logic                       dataClk,
    input  logic                       rs,
    input  logic                       cs,
    input  logic [addrWidth-1:0]       addr,
    input  logic [dataWidth-1:0]       dataIn,
    input  logic                       wr0,
    input  logic                       wr1,
    input  logic                       wr2,
    input  logic                       wr3,
    output logic [dataWidth-1:0]       dataOut,
    output logic                       bitsyncEnable,
    output logic                       bertEnable,
    output logic                       framesyncEnable,
    output logic                       pnGeneratorEnable,
    output logic [dacSelWidth-1:0]     dac0InputSelect,
    output logic [dacSelWidth-1:0]     dac1InputSelect,
    output logic [dacSelWidth-1:0]     dac2InputSelect,
    output logic [muxSelWidth-1:0]     bsCoaxMuxSelect,
    output logic [muxSelWidth-1:0]     encCoaxMuxSelect,
    output logic [muxSelWidth-1:0]     fsMuxSelect,
    output logic [muxSelWidth-1:0]     bsRS422MuxSelect,
    output logic [muxSelWidth-1:0]     fsRS422MuxSelect,
    output logic [muxSelWidth-1:0]     bertMuxSelect,
    output logic [muxSelWidth-1:0]     framerMuxSelect,
    output logic [rebootAddrWidth-1:0] rebootAddress,
    output logic                       reboot,
    output logic                       subsystemReset
);

    regAddrT              rdSel;
    regAddrT              wrSel;
    logic [laneCount-1:0] wrLanes;
    logic [dataWidth-1:0] wrData;
    logic                 wrStrobe;
    logic                 resetCmd;
    logic                 rebootCmd;
    logic                 resetSync;

    busDecode busDecode_i (
        .busClk   (busClk),
        .rs       (rs),
        .cs       (cs),
        .addr     (addr),
        .dataIn   (dataIn),
        .wr       ({wr3, wr2, wr1, wr0}),       // lane 0 is the low byte.
        .rdSel    (rdSel),
        .wrSel    (wrSel),
        .wrLanes  (wrLanes),
        .wrData   (wrData),
        .wrStrobe (wrStrobe)
    );

    sysRegFile sysRegFile_i (
        .busClk            (busClk),
        .rs                (rs),
        .cs                (cs),
        .rdSel             (rdSel),
        .wrSel             (wrSel),
        .wrLanes           (wrLanes),
        .wrData            (wrData),
        .wrStrobe          (wrStrobe),
        .dataOut           (dataOut),
        .bitsyncEnable     (bitsyncEnable),
        .bertEnable        (bertEnable),
        .framesyncEnable   (framesyncEnable),
        .pnGeneratorEnable (pnGeneratorEnable),
        .dac0InputSelect   (dac0InputSelect),
        .dac1InputSelect   (dac1InputSelect),
        .dac2InputSelect   (dac2InputSelect),
        .bsCoaxMuxSelect   (bsCoaxMuxSelect),
        .encCoaxMuxSelect  (encCoaxMuxSelect),
        .fsMuxSelect       (fsMuxSelect),
        .bsRS422MuxSelect  (bsRS422MuxSelect),
        .fsRS422MuxSelect  (fsRS422MuxSelect),
        .bertMuxSelect     (bertMuxSelect),
        .framerMuxSelect   (framerMuxSelect),
        .rebootAddress     (rebootAddress),
        .resetCmd          (resetCmd),
        .rebootCmd         (rebootCmd)
    );

    pulseSync resetSyncI (
        .busClk   (busClk),
        .dataClk  (dataClk),
        .rs       (rs),
        .pulseIn  (resetCmd),
        .pulseOut (resetSync)
    );

    pulseSync rebootSyncI (
        .busClk   (busClk),
        .dataClk  (dataClk),
        .rs       (rs),
        .pulseIn  (rebootCmd),
        .pulseOut (reboot)                      // one dataClk cycle per command.
    );

    resetPulseGen resetPulseGen_i (
        .dataClk        (dataClk),
        .rs             (rs),
        .resetSync      (resetSync),
        .subsystemReset (subsystemReset)
    );

endmodule

// File: sysCtrl_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions for the system control block.
//   - reset state of controls and dataClk pulses
//   - read behavior with cs low, identity and command words
//   - subsystemReset and reboot pulse widths
//   - bind onto the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sysCtrlProperties import sysCtrlPkg::*; (
    input logic                 busClk,
    input logic                 dataClk,
    input logic                 rs,
    input logic                 cs,
    input regAddrT              rdSel,
    input logic [dataWidth-1:0] dataOut,
    input logic [64:0]          ctrlState,          // every enable, select and rebootAddress.
    input logic                 resetSync,
    input logic                 reboot,
    input logic                 subsystemReset
);

    int failCount = 0;

    resetStateA: assert property (@(posedge busClk) (rs || $fell(rs)) |-> ctrlState == '0)
        else begin
            failCount++;
            $error("control outputs not cleared by reset");
        end

    resetPulsesA: assert property (@(posedge dataClk)
            (rs || $fell(rs)) |-> (!reboot && !subsystemReset))
        else begin
            failCount++;
            $error("dataClk pulses active during reset");
        end

    csLowA: assert property (@(posedge busClk) disable iff (rs) !cs |-> dataOut == '0)
        else begin
            failCount++;
            $error("dataOut not zero while cs is low");
        end

    versionA: assert property (@(posedge busClk) disable iff (rs)
            (cs && rdSel == regVersion) |-> dataOut == {versionNumber, 16'h0000})
        else begin
            failCount++;
            $error("version word read back wrong");
        end

    cmdReadA: assert property (@(posedge busClk) disable iff (rs)
            (cs && rdSel inside {regNone, regReset, regReboot}) |-> dataOut == '0)
        else begin
            failCount++;
            $error("command or unmapped address read non-zero");
        end

    resetStartA: assert property (@(posedge dataClk) disable iff (rs)
            resetSync |=> subsystemReset)
        else begin
            failCount++;
            $error("subsystemReset did not follow resetSync");
        end

    resetWidthA: assert property (@(posedge dataClk) disable iff (rs)
            $rose(subsystemReset) |-> subsystemReset [*resetPulseLength] ##1 !subsystemReset)
        else begin
            failCount++;
            $error("subsystemReset pulse has the wrong width");
        end

    rebootWidthA: assert property (@(posedge dataClk) disable iff (rs) reboot |=> !reboot)
        else begin
            failCount++;
            $error("reboot held longer than one dataClk cycle");
        end

endmodule

bind sysCtrlTop sysCtrlProperties sysCtrlPropsI (
    .busClk         (busClk),
    .dataClk        (dataClk),
    .rs             (rs),
    .cs             (cs),
    .rdSel          (rdSel),
    .dataOut        (dataOut),
    .ctrlState      ({bitsyncEnable, bertEnable, framesyncEnable, pnGeneratorEnable,
                      dac0InputSelect, dac1InputSelect, dac2InputSelect,
                      bsCoaxMuxSelect, encCoaxMuxSelect, fsMuxSelect, bsRS422MuxSelect,
                      fsRS422MuxSelect, bertMuxSelect, framerMuxSelect, rebootAddress}),
    .resetSync      (resetSync),
    .reboot         (reboot),
    .subsystemReset (subsystemReset)
);

// File: sysCtrlTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the system control block.
//   - bus and data clocks, reset and watchdog
//   - register writes with readback against a shadow model
//   - soft-reset and reboot command checks
//   - closing error summary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sysCtrlTb import sysCtrlPkg::*; ();

    localparam int testCycles = 300;                // sequence length in busClk cycles.

    logic                       busClk;
    logic                       dataClk;
    logic                       rs;
    logic                       cs;
    logic [addrWidth-1:0]       addr;
    logic [dataWidth-1:0]       dataIn;
    logic                       wr0, wr1, wr2, wr3;
    logic [dataWidth-1:0]       dataOut;
    logic                       bitsyncEnable, bertEnable, framesyncEnable, pnGeneratorEnable;
    logic [dacSelWidth-1:0]     dac0InputSelect, dac1InputSelect, dac2InputSelect;
    logic [muxSelWidth-1:0]     bsCoaxMuxSelect, encCoaxMuxSelect, fsMuxSelect;
    logic [muxSelWidth-1:0]     bsRS422MuxSelect, fsRS422MuxSelect;
    logic [muxSelWidth-1:0]     bertMuxSelect, framerMuxSelect;
    logic [rebootAddrWidth-1:0] rebootAddress;
    logic                       reboot;
    logic                       subsystemReset;

    logic [dataWidth-1:0]       shadow [0:8];       // expected readback per mapped address.
    logic [rebootAddrWidth-1:0] rebootModel;
    int                         errorCount = 0;

    sysCtrlTop sysCtrlTop_i (.*);

    initial begin
        busClk = 1'b0;
        forever #2 busClk = ~busClk;
    end

    initial begin
        dataClk = 1'b0;
        forever #3 dataClk = ~dataClk;              // unrelated to busClk on purpose.
    end

    initial begin
        repeat (testCycles * 2 + 200) @(posedge busClk);
        $display("timeout: the test sequence did not finish in %0d busClk cycles",
                 testCycles * 2 + 200);
        $display("CHECKS FAILED");
        $finish;
    end

    // writable bits per address, from the register field layout.
    function automatic logic [dataWidth-1:0] fieldMask(input logic [addrWidth-1:0] a);
        case (a)
            regSubsystemCtrl: return 32'h0000_000f;
            regDacInputSel:   return 32'h0007_0707;
            regOutputSel:     return 32'h00ff_0fff;    // nibble 3 is unused.
            regBertMuxSel:    return 32'h0000_000f;
            regFramerMuxSel:  return 32'h000f_0000;
            default:          return 32'h0000_0000;
        endcase
    endfunction

    // bert and framer selects share one readback word
    function automatic int shadowSlot(input logic [addrWidth-1:0] a);
        return (a == regFramerMuxSel) ? int'(regBertMuxSel) : int'(a);
    endfunction

    function automatic logic [dataWidth-1:0] expectedRead(input logic [addrWidth-1:0] a);
        case (a)
            regVersion: return {versionNumber, 16'h0000};
            regType:    return {16'h0000, imageType};
            regSubsystemCtrl, regDacInputSel, regOutputSel, regBertMuxSel, regFramerMuxSel:
                return shadow[shadowSlot(a)];
            default:    return '0;                 // commands and unmapped.
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] want,
                              input logic [dataWidth-1:0] got);
        assert (got === want)
        else begin
            errorCount++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic checkTrue(input bit ok, input string what);
        assert (ok)
        else begin
            errorCount++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    // control output ports packed in register layout against the model
    task automatic checkOutputs();
        checkValue("pnGeneratorEnable..bitsyncEnable", expectedRead(regSubsystemCtrl),
                   {28'h0, pnGeneratorEnable, framesyncEnable, bertEnable, bitsyncEnable});
        checkValue("dac2..dac0InputSelect", expectedRead(regDacInputSel),
                   {13'h0, dac2InputSelect, 5'h0, dac1InputSelect, 5'h0, dac0InputSelect});
        checkValue("routing mux selects", expectedRead(regOutputSel),
                   {8'h00, fsRS422MuxSelect, fsMuxSelect, 4'h0, encCoaxMuxSelect,
                    bsRS422MuxSelect, bsCoaxMuxSelect});
        checkValue("framerMuxSelect, bertMuxSelect", expectedRead(regBertMuxSel),
                   {12'h000, framerMuxSelect, 12'h000, bertMuxSelect});
        checkValue("rebootAddress", {8'h00, rebootModel}, {8'h00, rebootAddress});
    endtask

    task automatic writeReg(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d,
                            input logic [laneCount-1:0] lanes);
        logic [dataWidth-1:0] m;
        logic [dataWidth-1:0] msk;
        @(negedge busClk);
        cs = 1'b1;
        addr = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = lanes;
        m = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        msk = fieldMask(a) & m;
        if (a == regReboot) begin
            rebootModel = (rebootModel & ~m[23:0]) | (d[23:0] & m[23:0]);
        end else if (fieldMask(a) != '0) begin
            shadow[shadowSlot(a)] = (shadow[shadowSlot(a)] & ~msk) | (d & msk);
        end
        @(negedge busClk);
        cs = 1'b0;                                  // one idle cycle before any read.
        {wr3, wr2, wr1, wr0} = '0;
    endtask

    task automatic readReg(input logic [addrWidth-1:0] a);
        @(negedge busClk);
        cs = 1'b1;
        addr = a;
        {wr3, wr2, wr1, wr0} = '0;
        #1;
        checkValue($sformatf("dataOut (addr %0h)", a), expectedRead(a), dataOut);
        checkOutputs();
    endtask

    // counts dataClk cycles until the chosen pulse shows up
    task automatic awaitPulse(input bit useReboot, output int edges);
        edges = 0;
        while (!(useReboot ? reboot : subsystemReset) && edges < 12) begin
            @(negedge dataClk);
            edges++;
        end
    endtask

    task automatic checkQuiet(input bit useReboot, input int cycles, input string what);
        repeat (cycles) begin
            @(negedge dataClk);
            checkTrue(!(useReboot ? reboot : subsystemReset), what);
        end
    endtask

    task automatic softResetCheck();
        int edges;
        writeReg(regReset, $urandom(), 4'b0001);
        awaitPulse(1'b0, edges);
        checkTrue(edges <= 4, "subsystemReset did not rise within four dataClk cycles");
        while (subsystemReset) @(negedge dataClk);
        checkQuiet(1'b0, 10, "a second subsystemReset pulse followed one soft-reset write");
    endtask

    task automatic rebootCheck();
        int edges;
        writeReg(regReboot, $urandom(), 4'b1111);
        awaitPulse(1'b1, edges);
        checkTrue(edges <= 4, "reboot did not pulse within four dataClk cycles");
        checkValue("rebootAddress", {8'h00, rebootModel}, {8'h00, rebootAddress});
        checkQuiet(1'b1, 8, "reboot stayed high or pulsed twice after one write");
    endtask

    initial begin
        logic [addrWidth-1:0] writable [5];
        logic [addrWidth-1:0] junkAddr;
        logic [laneCount-1:0] lanes;
        int                   propFails;
        void'($urandom(32'h4501_25ab));
        rs = 1'b1;
        cs = 1'b0;
        addr = '0;
        dataIn = '0;
        {wr3, wr2, wr1, wr0} = '0;
        for (int i = 0; i <= 8; i++) shadow[i] = '0;
        rebootModel = '0;
        writable = '{regSubsystemCtrl, regDacInputSel, regOutputSel, regBertMuxSel,
                     regFramerMuxSel};
        repeat (8) @(posedge busClk);
        @(negedge busClk);
        rs = 1'b0;

        for (int a = 0; a <= 8; a++) readReg(addrWidth'(a));   // power-up values.
        readReg(regNone);

        foreach (writable[i]) begin
            writeReg(writable[i], $urandom(), 4'b1111);
            readReg(writable[i]);
        end
        readReg(regBertMuxSel);
        readReg(regFramerMuxSel);

        foreach (writable[i]) begin
            for (int lane = 0; lane < laneCount; lane++) begin
                lanes = '0;
                lanes[lane] = 1'b1;
                writeReg(writable[i], $urandom(), lanes);
                readReg(writable[i]);
            end
        end

        repeat (4) begin
            junkAddr = addrWidth'($urandom_range(8191, 9));     // anything past regReset.
            writeReg(junkAddr, $urandom(), 4'b1111);
            readReg(junkAddr);
        end
        foreach (writable[i]) readReg(writable[i]);
        readReg(regReset);
        readReg(regReboot);

        softResetCheck();
        softResetCheck();
        writeReg(regReset, $urandom(), 4'b0010);
        checkQuiet(1'b0, 10, "a lane-1 write to regReset gave a subsystemReset pulse");
        rebootCheck();
        writeReg(regReboot, $urandom(), 4'b0001);
        checkQuiet(1'b1, 8, "a lane-0 write to regReboot gave a reboot pulse");
        checkValue("rebootAddress", {8'h00, rebootModel}, {8'h00, rebootAddress});
        rebootCheck();

        @(negedge busClk);
        cs = 1'b0;
        propFails = sysCtrlTop_i.sysCtrlPropsI.failCount;
        $display("summary: %0d readback or pulse errors, %0d property failures",
                 errorCount, propFails);
        if (errorCount == 0 && propFails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
sysCtrlPkg.sv
busDecode.sv
sysRegFile.sv
pulseSync.sv
resetPulseGen.sv
sysCtrlTop.sv
sysCtrl_properties.sv
sysCtrlTb.sv

// File: Makefile
# Verilator flow for the system control block.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= sysCtrlTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
